//--- build.f
rvIsaPkg.sv
coreTypesPkg.sv
instDecode.sv
regFile.sv
aluExecute.sv
branchUnit.sv
retireStage.sv
rv32Core.sv
tbCore.sv

//--- Makefile
# Verilator flow for the rv32Core testbench

.PHONY: all lint clean

all:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module tbCore -f build.f -o simCore
	@out=$$(./obj_dir/simCore); echo "$$out"; echo "$$out" | grep -qx "sim passed"

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps \
		--top-module tbCore -f build.f

clean:
	rm -rf obj_dir

//--- tbCore.sv
`timescale 1ns/1ps

module tbCore import rvIsaPkg::*; import coreTypesPkg::*; ();

    localparam wordT        ResetPc    = '0;
    localparam int          Timeout    = 50; // cycles per wait
    localparam int          HaltCycles = 20;
    localparam logic [31:0] Seed       = 32'h8c1f_f7b2;

    typedef struct packed {
        wordT   inst;
        retireT exp;
    } rowT;

    logic   clk = 1'b0;
    logic   rst;
    logic   instValid;
    wordT   instWord;
    logic   instReady;
    logic   retireValid;
    retireT retire;
    logic   retireReady;

    logic [31:0] rngState = Seed;
    rowT         rows[$];
    string       names[$];
    logic        accepted[];
    wordT        tablePc = ResetPc;

    rv32Core #(
        .ResetPc (ResetPc)
    ) dut0 (
        .clk         (clk),
        .rst         (rst),
        .instValid   (instValid),
        .instWord    (instWord),
        .instReady   (instReady),
        .retireValid (retireValid),
        .retire      (retire),
        .retireReady (retireReady)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] nextRandom(logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // random back-pressure on the retire side
    always @(posedge clk) begin
        #1;
        rngState    = nextRandom(rngState);
        retireReady = rngState[0];
    end

    // small assembler for the program table
    function automatic wordT encR(logic [6:0] f7, logic [2:0] f3, regAddrT rd,
                                  regAddrT rs1, regAddrT rs2);
        return {f7, rs2, rs1, f3, rd, OpReg};
    endfunction

    function automatic wordT encI(opcodeT op, logic [2:0] f3, regAddrT rd,
                                  regAddrT rs1, logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic wordT encU(opcodeT op, regAddrT rd, logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    function automatic wordT encJ(regAddrT rd, int off);
        logic [20:0] o;
        o = off[20:0];
        return {o[20], o[10:1], o[11], o[19:12], rd, OpJal};
    endfunction

    function automatic wordT encB(logic [2:0] f3, regAddrT rs1, regAddrT rs2, int off);
        logic [12:0] o;
        o = off[12:0];
        return {o[12], o[10:5], rs2, rs1, f3, o[4:1], o[11], OpBranch};
    endfunction

    function automatic wordT encS(logic [2:0] f3, regAddrT rs1, regAddrT rs2, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OpStore};
    endfunction

    task automatic abortRun();
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic failPlain(string msg);
        $display("%s", msg);
        abortRun();
    endtask

    task automatic checkWord(string name, wordT exp, wordT act);
        if (act !== exp) begin
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
            abortRun();
        end
    endtask

    task automatic checkFlag(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("FAIL %s: expected %b, actual %b", name, exp, act);
            abortRun();
        end
    endtask

    // exact compares every bit, otherwise rd and rdData only count when written
    task automatic checkRetire(string name, retireT exp, retireT act, logic exact);
        if (exact) begin
            if (act !== exp) begin
                $display("FAIL %s: expected %h, actual %h", name, exp, act);
                abortRun();
            end
        end else begin
            checkWord({name, " pc"}, exp.pc, act.pc);
            checkWord({name, " nextPc"}, exp.nextPc, act.nextPc);
            checkFlag({name, " rdWen"}, exp.rdWen, act.rdWen);
            checkFlag({name, " halt"}, exp.halt, act.halt);
            if (exp.rdWen) begin
                checkWord({name, " rd"}, wordT'(exp.rd), wordT'(act.rd));
                checkWord({name, " rdData"}, exp.rdData, act.rdData);
            end
        end
    endtask

    task automatic addEntry(string name, wordT inst, regAddrT rd, wordT rdData,
                            logic rdWen, wordT nextPc, logic halt);
        rowT row;
        row.inst       = inst;
        row.exp.pc     = tablePc;
        row.exp.nextPc = nextPc;
        row.exp.rd     = rd;
        row.exp.rdData = rdData;
        row.exp.rdWen  = rdWen;
        row.exp.halt   = halt;
        rows.push_back(row);
        names.push_back(name);
        tablePc = nextPc; // words arrive in order, pc follows each record
    endtask

    task automatic addRow(string name, wordT inst, regAddrT rd, wordT rdData, wordT nextPc);
        addEntry(name, inst, rd, rdData, 1'b1, nextPc, 1'b0);
    endtask

    task automatic addFlow(string name, wordT inst, wordT nextPc, logic halt);
        addEntry(name, inst, '0, '0, 1'b0, nextPc, halt);
    endtask

    task automatic buildProgram();
        addRow("addi x1", encI(OpImm, F3Add, 5'd1, 5'd0, 12'd5), 5'd1, 32'h5, 32'h4);
        addRow("addi x2", encI(OpImm, F3Add, 5'd2, 5'd0, 12'hffd), 5'd2, 32'hffff_fffd, 32'h8);
        addRow("add", encR(7'd0, F3Add, 5'd3, 5'd1, 5'd2), 5'd3, 32'h2, 32'hc);
        addRow("sub", encR(Funct7Alt, F3Add, 5'd4, 5'd1, 5'd2), 5'd4, 32'h8, 32'h10);
        addRow("xor", encR(7'd0, F3Xor, 5'd5, 5'd1, 5'd2), 5'd5, 32'hffff_fff8, 32'h14);
        addRow("or", encR(7'd0, F3Or, 5'd6, 5'd1, 5'd2), 5'd6, 32'hffff_fffd, 32'h18);
        addRow("and", encR(7'd0, F3And, 5'd7, 5'd1, 5'd2), 5'd7, 32'h5, 32'h1c);
        addRow("slt", encR(7'd0, F3Slt, 5'd8, 5'd2, 5'd1), 5'd8, 32'h1, 32'h20);
        addRow("sltu", encR(7'd0, F3Sltu, 5'd9, 5'd2, 5'd1), 5'd9, 32'h0, 32'h24);
        addRow("sll", encR(7'd0, F3Sll, 5'd10, 5'd1, 5'd1), 5'd10, 32'ha0, 32'h28);
        addRow("srl", encR(7'd0, F3Sr, 5'd11, 5'd2, 5'd1), 5'd11, 32'h07ff_ffff, 32'h2c);
        addRow("sra", encR(Funct7Alt, F3Sr, 5'd12, 5'd2, 5'd1), 5'd12, 32'hffff_ffff, 32'h30);
        addRow("slti", encI(OpImm, F3Slt, 5'd13, 5'd2, 12'hffe), 5'd13, 32'h1, 32'h34);
        addRow("srai", encI(OpImm, F3Sr, 5'd14, 5'd2, 12'h401), 5'd14, 32'hffff_fffe, 32'h38);
        addRow("lui", encU(OpLui, 5'd15, 20'h12345), 5'd15, 32'h1234_5000, 32'h3c);
        addRow("auipc", encU(OpAuipc, 5'd16, 20'h1), 5'd16, 32'h103c, 32'h40);
        addRow("jal", encJ(5'd17, 16), 5'd17, 32'h44, 32'h50);
        addRow("addi x18", encI(OpImm, F3Add, 5'd18, 5'd0, 12'h101), 5'd18, 32'h101, 32'h54);
        addRow("jalr", encI(OpJalr, 3'b000, 5'd19, 5'd18, 12'd0), 5'd19, 32'h58, 32'h100);
        addRow("addi x0", encI(OpImm, F3Add, 5'd0, 5'd0, 12'd7), 5'd0, 32'h7, 32'h104);
        addRow("read x0", encR(7'd0, F3Add, 5'd20, 5'd0, 5'd0), 5'd20, 32'h0, 32'h108);
        addFlow("beq taken", encB(F3Beq, 5'd1, 5'd7, 8), 32'h110, 1'b0);
        addFlow("beq not", encB(F3Beq, 5'd1, 5'd2, 8), 32'h114, 1'b0);
        addFlow("bne taken", encB(F3Bne, 5'd1, 5'd2, 12), 32'h120, 1'b0);
        addFlow("bne not", encB(F3Bne, 5'd1, 5'd7, 8), 32'h124, 1'b0);
        addFlow("blt taken", encB(F3Blt, 5'd2, 5'd1, -16), 32'h114, 1'b0); // backward
        addFlow("blt not", encB(F3Blt, 5'd1, 5'd2, 8), 32'h118, 1'b0);
        addFlow("bge taken", encB(F3Bge, 5'd1, 5'd2, 8), 32'h120, 1'b0);
        addFlow("bge not", encB(F3Bge, 5'd2, 5'd1, 8), 32'h124, 1'b0);
        addFlow("bltu taken", encB(F3Bltu, 5'd1, 5'd2, 8), 32'h12c, 1'b0);
        addFlow("bltu not", encB(F3Bltu, 5'd2, 5'd1, 8), 32'h130, 1'b0);
        addFlow("bgeu taken", encB(F3Bgeu, 5'd2, 5'd1, 8), 32'h138, 1'b0);
        addFlow("bgeu not", encB(F3Bgeu, 5'd1, 5'd2, 8), 32'h13c, 1'b0);
        addFlow("sw halts", encS(3'b010, 5'd0, 5'd1, 12'd0), 32'h13c, 1'b1);
    endtask

    // present one word and hold it until the accepting edge
    task automatic issueRow(int i);
        int t;
        instValid = 1'b1;
        instWord  = rows[i].inst;
        t = 0;
        @(negedge clk);
        while (!instReady) begin
            t++;
            if (t == Timeout) begin
                failPlain($sformatf("timeout waiting for instReady to take %s", names[i]));
            end
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        accepted[i] = 1'b1;
    endtask

    task automatic collectRow(int i);
        int     t;
        retireT held;
        t = 0;
        @(negedge clk);
        while (!retireValid) begin
            if (accepted[i]) begin
                failPlain($sformatf("no record one cycle after accepting %s", names[i]));
            end
            t++;
            if (t == Timeout) begin
                failPlain($sformatf("timeout waiting for retireValid of %s", names[i]));
            end
            @(negedge clk);
        end
        if (!accepted[i]) begin
            failPlain($sformatf("a record showed up before %s was accepted", names[i]));
        end
        checkRetire(names[i], rows[i].exp, retire, 1'b0);
        held = retire;
        t = 0;
        while (!retireReady) begin // stalled, record must hold
            t++;
            if (t == Timeout) begin
                failPlain($sformatf("timeout waiting for retireReady on %s", names[i]));
            end
            @(negedge clk);
            checkFlag({names[i], " stalled valid"}, 1'b1, retireValid);
            checkRetire({names[i], " stalled"}, held, retire, 1'b1);
        end
    endtask

    initial begin
        rst         = 1'b0;
        instValid   = 1'b0;
        instWord    = '0;
        retireReady = 1'b0;
        buildProgram();
        accepted = new[rows.size()];
        foreach (accepted[i]) begin
            accepted[i] = 1'b0;
        end
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b1;
        @(negedge clk);
        checkFlag("reset retireValid", 1'b0, retireValid);
        checkFlag("reset instReady", 1'b1, instReady);
        fork
            begin
                @(posedge clk);
                #1;
                for (int i = 0; i < rows.size(); i++) begin
                    issueRow(i);
                end
                instWord = encI(OpImm, F3Add, 5'd1, 5'd1, 12'd1); // offered after halt
            end
            begin
                for (int i = 0; i < rows.size(); i++) begin
                    collectRow(i);
                end
            end
        join
        for (int c = 0; c < HaltCycles; c++) begin
            @(negedge clk);
            checkFlag("halted instReady", 1'b0, instReady);
            checkFlag("halted retireValid", 1'b0, retireValid);
        end
        $display("sim passed");
        $finish;
    end

endmodule

//--- rv32Core.sv
`timescale 1ns/1ps

module rv32Core import coreTypesPkg::*; #(
    parameter wordT ResetPc = '0
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   instValid,
    input  wordT   instWord,
    output logic   instReady,
    output logic   retireValid,
    output retireT retire,
    input  logic   retireReady
);

    decodedT dec;
    wordT    rdataA;
    wordT    rdataB;
    wordT    rdData;
    wordT    nextPc;
    wordT    pc;
    logic    wen;
    regAddrT waddr;
    wordT    wdata;

    instDecode dec0 (
        .instWord (instWord),
        .dec      (dec)
    );

    regFile rf0 (
        .clk    (clk),
        .rst    (rst),
        .raddrA (dec.rs1),
        .raddrB (dec.rs2),
        .rdataA (rdataA),
        .rdataB (rdataB),
        .wen    (wen),
        .waddr  (waddr),
        .wdata  (wdata)
    );

    aluExecute alu0 (
        .dec    (dec),
        .pc     (pc),
        .opA    (rdataA),
        .opB    (rdataB),
        .rdData (rdData)
    );

    branchUnit bu0 (
        .dec    (dec),
        .pc     (pc),
        .opA    (rdataA),
        .opB    (rdataB),
        .nextPc (nextPc)
    );

    retireStage #(
        .ResetPc (ResetPc)
    ) rs0 (
        .clk         (clk),
        .rst         (rst),
        .instValid   (instValid),
        .instReady   (instReady),
        .dec         (dec),
        .rdData      (rdData),
        .nextPc      (nextPc),
        .pc          (pc),
        .wen         (wen),
        .waddr       (waddr),
        .wdata       (wdata),
        .retireValid (retireValid),
        .retireReady (retireReady),
        .retire      (retire)
    );

endmodule

//--- retireStage.sv
`timescale 1ns/1ps

module retireStage import coreTypesPkg::*; #(
    parameter wordT ResetPc = '0
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    instValid,
    output logic    instReady,
    input  decodedT dec,
    input  wordT    rdData,
    input  wordT    nextPc,
    output wordT    pc,
    output logic    wen,
    output regAddrT waddr,
    output wordT    wdata,
    output logic    retireValid,
    input  logic    retireReady,
    output retireT  retire
);

    logic halted;
    logic accept;

    // one record in flight, drain and refill in the same cycle
    assign instReady = !halted && (!retireValid || retireReady);
    assign accept    = instValid && instReady;

    assign wen   = accept && dec.rdWen;
    assign waddr = dec.rd;
    assign wdata = rdData;

    always_ff @(posedge clk) begin
        if (!rst) begin
            pc          <= ResetPc;
            halted      <= 1'b0;
            retireValid <= 1'b0;
        end else if (accept) begin
            pc          <= nextPc; // equals pc on illegal
            halted      <= dec.illegal;
            retireValid <= 1'b1;
        end else if (retireReady) begin
            retireValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            retire.pc     <= pc;
            retire.nextPc <= nextPc;
            retire.rd     <= dec.rd;
            retire.rdData <= rdData;
            retire.rdWen  <= dec.rdWen;
            retire.halt   <= dec.illegal;
        end
    end

    stallHoldsRecord: assert property (@(posedge clk) disable iff (!rst)
        retireValid && !retireReady |=> retireValid && $stable(retire));

    haltIsFinal: assert property (@(posedge clk) disable iff (!rst)
        halted |=> halted && $stable(pc) && !wen);

    // illegal word retires in place
    haltRecordSelfPc: assert property (@(posedge clk) disable iff (!rst)
        accept && dec.illegal |=> retire.halt && !retire.rdWen && retire.nextPc == retire.pc);

endmodule

//--- branchUnit.sv
`timescale 1ns/1ps

module branchUnit import rvIsaPkg::*; import coreTypesPkg::*; (
    input  decodedT dec,
    input  wordT    pc,
    input  wordT    opA,
    input  wordT    opB,
    output wordT    nextPc
);

    logic taken;
    wordT jalrSum;

    always_comb begin
        case (dec.branchF3)
            F3Beq:   taken = opA == opB;
            F3Bne:   taken = opA != opB;
            F3Blt:   taken = $signed(opA) < $signed(opB);
            F3Bge:   taken = $signed(opA) >= $signed(opB);
            F3Bltu:  taken = opA < opB;
            F3Bgeu:  taken = opA >= opB;
            default: taken = 1'b0; // 010, 011 are illegal
        endcase
    end

    assign jalrSum = opA + dec.imm;

    always_comb begin
        if (dec.illegal) begin
            nextPc = pc; // halted, pc holds
        end else if (dec.isJal) begin
            nextPc = pc + dec.imm;
        end else if (dec.isJalr) begin
            nextPc = {jalrSum[XLEN-1:1], 1'b0};
        end else if (dec.isBranch && taken) begin
            nextPc = pc + dec.imm;
        end else begin
            nextPc = pc + InstBytes;
        end
    end

endmodule

//--- aluExecute.sv
`timescale 1ns/1ps

module aluExecute import rvIsaPkg::*; import coreTypesPkg::*; (
    input  decodedT dec,
    input  wordT    pc,
    input  wordT    opA,
    input  wordT    opB,
    output wordT    rdData
);

    localparam int ShamtW = $clog2(XLEN);

    wordT              srcB;
    wordT              aluResult;
    logic [ShamtW-1:0] shamt;

    assign srcB  = dec.useImm ? dec.imm : opB; // imm or rs2
    assign shamt = srcB[ShamtW-1:0];

    always_comb begin
        case (dec.aluOp)
            AluAdd: begin
                aluResult = opA + srcB;
            end
            AluSub: begin
                aluResult = opA - srcB;
            end
            AluSll: begin
                aluResult = opA << shamt;
            end
            AluSlt: begin
                aluResult = wordT'($signed(opA) < $signed(srcB));
            end
            AluSltu: begin
                aluResult = wordT'(opA < srcB);
            end
            AluXor: begin
                aluResult = opA ^ srcB;
            end
            AluSrl: begin
                aluResult = opA >> shamt;
            end
            AluSra: begin
                aluResult = $signed(opA) >>> shamt; // sign fill
            end
            AluOr: begin
                aluResult = opA | srcB;
            end
            AluAnd: begin
                aluResult = opA & srcB;
            end
            AluPassB: begin
                aluResult = srcB; // lui
            end
            default: begin
                aluResult = '0;
            end
        endcase
    end

    // result by instruction kind
    always_comb begin
        if (dec.isAuipc) begin
            rdData = pc + dec.imm;
        end else if (dec.isJal || dec.isJalr) begin
            rdData = pc + InstBytes; // link address
        end else begin
            rdData = aluResult;
        end
    end

endmodule

//--- regFile.sv
`timescale 1ns/1ps

module regFile import rvIsaPkg::*; import coreTypesPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  regAddrT raddrA,
    input  regAddrT raddrB,
    output wordT    rdataA,
    output wordT    rdataB,
    input  logic    wen,
    input  regAddrT waddr,
    input  wordT    wdata
);

    localparam int NumRegs = 2 ** RegAddrW;

    wordT regs [NumRegs];

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin // x0 never written
            regs[waddr] <= wdata;
        end
    end

    assign rdataA = regs[raddrA];
    assign rdataB = regs[raddrB];

    // x0 must still be zero after any sequence of writes
    x0ReadsZeroA: assert property (@(posedge clk) disable iff (!rst)
        raddrA == '0 |-> rdataA == '0);
    x0ReadsZeroB: assert property (@(posedge clk) disable iff (!rst)
        raddrB == '0 |-> rdataB == '0);

endmodule

//--- instDecode.sv
`timescale 1ns/1ps

module instDecode import rvIsaPkg::*; import coreTypesPkg::*; (
    input  wordT    instWord,
    output decodedT dec
);

    opcodeT             opcode;
    f3AluT              funct3;
    logic [Funct7W-1:0] funct7;
    wordT               immI;
    wordT               immU;
    wordT               immJ;
    wordT               immB;
    logic               f7Zero;
    logic               f7ZeroOrAlt;
    logic               writes;

    function automatic aluOpT aluOpOf(f3AluT f3, logic alt);
        aluOpT op;
        case (f3)
            F3Add:   op = alt ? AluSub : AluAdd;
            F3Sll:   op = AluSll;
            F3Slt:   op = AluSlt;
            F3Sltu:  op = AluSltu;
            F3Xor:   op = AluXor;
            F3Sr:    op = alt ? AluSra : AluSrl;
            F3Or:    op = AluOr;
            F3And:   op = AluAnd;
            default: op = AluAdd;
        endcase
        return op;
    endfunction

    assign opcode = opcodeT'(instWord[OpcodeW-1:0]);
    assign funct3 = f3AluT'(instWord[14:12]);
    assign funct7 = instWord[31:25];

    assign immI = {{20{instWord[31]}}, instWord[31:20]};
    assign immU = {instWord[31:12], 12'b0};
    assign immJ = {{12{instWord[31]}}, instWord[19:12], instWord[20], instWord[30:21], 1'b0};
    assign immB = {{20{instWord[31]}}, instWord[7], instWord[30:25], instWord[11:8], 1'b0};

    assign f7Zero      = funct7 == '0;
    assign f7ZeroOrAlt = f7Zero || funct7 == Funct7Alt;

    always_comb begin
        dec          = '0;
        writes       = 1'b0;
        dec.rs1      = instWord[19:15];
        dec.rs2      = instWord[24:20];
        dec.rd       = instWord[11:7];
        dec.branchF3 = f3BranchT'(instWord[14:12]);
        case (opcode)
            OpLui: begin
                writes     = 1'b1;
                dec.useImm = 1'b1;
                dec.imm    = immU;
                dec.aluOp  = AluPassB;
            end
            OpAuipc: begin
                writes      = 1'b1;
                dec.isAuipc = 1'b1;
                dec.imm     = immU;
            end
            OpJal: begin
                writes    = 1'b1;
                dec.isJal = 1'b1;
                dec.imm   = immJ;
            end
            OpJalr: begin
                writes      = 1'b1;
                dec.isJalr  = 1'b1;
                dec.imm     = immI;
                dec.illegal = instWord[14:12] != 3'b000;
            end
            OpBranch: begin
                dec.isBranch = 1'b1;
                dec.imm      = immB;
                dec.illegal  = instWord[14:13] == 2'b01; // funct3 010, 011
            end
            OpImm: begin
                writes     = 1'b1;
                dec.useImm = 1'b1;
                dec.imm    = immI;
                dec.aluOp  = aluOpOf(funct3, funct3 == F3Sr && funct7 == Funct7Alt);
                dec.illegal = (funct3 == F3Sll && !f7Zero)
                           || (funct3 == F3Sr && !f7ZeroOrAlt); // shamt upper field
            end
            OpReg: begin
                writes      = 1'b1;
                dec.aluOp   = aluOpOf(funct3, funct7 == Funct7Alt);
                dec.illegal = (funct3 == F3Add || funct3 == F3Sr) ? !f7ZeroOrAlt : !f7Zero;
            end
            OpLoad, OpStore: dec.illegal = 1'b1; // no data memory
            default:         dec.illegal = 1'b1; // unknown opcode
        endcase
        dec.rdWen = writes && !dec.illegal;
    end

endmodule

//--- coreTypesPkg.sv
package coreTypesPkg;

    import rvIsaPkg::*;

    typedef logic [XLEN-1:0]     wordT;
    typedef logic [RegAddrW-1:0] regAddrT;

    // byte distance between sequential instructions
    localparam wordT InstBytes = wordT'(4);

    typedef enum logic [3:0] {
        AluAdd,
        AluSub,
        AluSll,
        AluSlt,
        AluSltu,
        AluXor,
        AluSrl,
        AluSra,
        AluOr,
        AluAnd,
        AluPassB // lui
    } aluOpT;

    // one decoded instruction, consumed by execute, branch and retire
    typedef struct packed {
        regAddrT  rs1;
        regAddrT  rs2;
        regAddrT  rd;
        aluOpT    aluOp;
        logic     useImm;   // second operand is imm
        wordT     imm;      // I, U, J or B form by opcode
        logic     isBranch;
        logic     isJal;
        logic     isJalr;
        logic     isAuipc;
        logic     rdWen;
        logic     illegal;
        f3BranchT branchF3;
    } decodedT;

    // one retired instruction
    typedef struct packed {
        wordT    pc;
        wordT    nextPc;
        regAddrT rd;
        wordT    rdData;
        logic    rdWen;
        logic    halt;
    } retireT;

endpackage

//--- rvIsaPkg.sv
package rvIsaPkg;

    localparam int XLEN     = 32;
    localparam int RegAddrW = 5;

    // instruction field widths
    localparam int OpcodeW = 7;
    localparam int Funct3W = 3;
    localparam int Funct7W = 7;

    // major opcodes, bits 6:0 of the instruction
    typedef enum logic [OpcodeW-1:0] {
        OpLui    = 7'b0110111,
        OpAuipc  = 7'b0010111,
        OpJal    = 7'b1101111,
        OpJalr   = 7'b1100111,
        OpBranch = 7'b1100011,
        OpImm    = 7'b0010011,
        OpReg    = 7'b0110011,
        OpLoad   = 7'b0000011, // not executed, decodes as illegal
        OpStore  = 7'b0100011  // not executed, decodes as illegal
    } opcodeT;

    typedef enum logic [Funct3W-1:0] {
        F3Beq  = 3'b000,
        F3Bne  = 3'b001,
        F3Blt  = 3'b100,
        F3Bge  = 3'b101,
        F3Bltu = 3'b110,
        F3Bgeu = 3'b111
    } f3BranchT;

    typedef enum logic [Funct3W-1:0] {
        F3Add  = 3'b000, // also sub
        F3Sll  = 3'b001,
        F3Slt  = 3'b010,
        F3Sltu = 3'b011,
        F3Xor  = 3'b100,
        F3Sr   = 3'b101, // srl and sra
        F3Or   = 3'b110,
        F3And  = 3'b111
    } f3AluT;

    localparam logic [Funct7W-1:0] Funct7Alt = 7'b0100000; // sub, sra

endpackage
